// ==== bench/dcache_input.txt ====
# write size addr wdata expected_rdata expected_hit, all hex
# size 0 byte, 1 half, 2 word; stores ignore the last two columns
0 2 00000100 00000000 5a5a0040 0
0 2 00000104 00000000 5a5a0041 1
0 2 00000108 00000000 5a5a0042 1
0 2 0000010c 00000000 5a5a0043 1
1 0 00000104 a5a5a511 00000000 0
0 2 00000104 00000000 5a5a0011 1
1 0 00000105 a5a5a522 00000000 0
0 2 00000104 00000000 5a5a2211 1
1 0 00000106 a5a5a533 00000000 0
0 2 00000104 00000000 5a332211 1
1 0 00000107 a5a5a544 00000000 0
0 2 00000104 00000000 44332211 1
1 1 00000108 1234beef 00000000 0
0 2 00000108 00000000 5a5abeef 1
1 1 0000010a 5678cafe 00000000 0
0 2 00000108 00000000 cafebeef 1
1 2 00002000 12345678 00000000 0
0 2 00002000 00000000 12345678 0
1 1 00003006 ffffabcd 00000000 0
0 2 00003004 00000000 abcd0c01 0
0 2 10000040 00000000 5e5a0010 0
0 2 10000040 00000000 5e5a0010 0
1 2 10000040 deadbeef 00000000 0
0 2 10000040 00000000 deadbeef 0
0 2 40000100 00000000 4a5a0040 0
1 0 40000102 12345677 00000000 0
0 2 40000100 00000000 4a770040 0
0 2 00000200 00000000 5a5a0080 0
0 2 00008208 00000000 5a5a2082 0
0 2 00000204 00000000 5a5a0081 0
0 2 0000820c 00000000 5a5a2083 0

// ==== sim.f ====
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_tag_array.sv
verilog/dcache_data_array.sv
verilog/dcache_store_merge.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
bench/tb_mem_model.sv
bench/tb_dcache.sv

// ==== Makefile ====
# Verilator simulation of the data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/tb_dcache.sv ====
`default_nettype none

module tb_dcache;

    timeunit 1ns;
    timeprecision 100ps;

    import dcache_pkg::*;

    localparam int    RESET_CYCLES      = 16;
    localparam int    CYCLES_PER_VECTOR = 64;
    localparam int    HIT_CYCLES        = 2;
    localparam string INPUT_FILE        = "bench/dcache_input.txt";

    // One line of the access list
    typedef struct packed {
        logic  write;
        size_t size;
        word_t addr;
        word_t wdata;
        word_t exp_rdata;
        logic  exp_hit;
    } vector_t;

    logic      clk = 1'b0;
    logic      rst;
    logic      core_req;
    core_cmd_t core_cmd;
    logic      core_wait;
    word_t     core_rdata;
    logic      mem_req;
    mem_cmd_t  mem_cmd;
    word_t     mem_rdata;
    logic      mem_wait;
    int        read_count;

    vector_t   vectors[$];
    bit        loaded = 1'b0;

    dcache_top i_dcache_top (
        .clk        (clk),
        .rst        (rst),
        .core_req   (core_req),
        .core_cmd   (core_cmd),
        .core_wait  (core_wait),
        .core_rdata (core_rdata),
        .mem_req    (mem_req),
        .mem_cmd    (mem_cmd),
        .mem_rdata  (mem_rdata),
        .mem_wait   (mem_wait)
    );

    tb_mem_model i_mem_model (
        .clk        (clk),
        .mem_req    (mem_req),
        .mem_cmd    (mem_cmd),
        .mem_wait   (mem_wait),
        .mem_rdata  (mem_rdata),
        .read_count (read_count)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    // ======================================================================
    // Failure handling and compare tasks
    // ======================================================================

    task automatic stop_run();
        $display("TB FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_rdata(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s expected %b, got %b",
                     $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_cycles(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("MISMATCH at %0t ns: %s expected %0d, got %0d",
                     $time, name, expected, actual);
            stop_run();
        end
    endtask

    // ======================================================================
    // Stimulus file and core-side driver
    // ======================================================================

    function automatic bit is_comment_line(input string text);
        if (text.len() == 0) begin
            return 1'b1;
        end
        return (text[0] == "#") || (text[0] == "\n") || (text[0] == "\r");
    endfunction

    task automatic load_vectors();
        int      fd;
        int      fields;
        string   text;
        logic    w;
        size_t   sz;
        word_t   a;
        word_t   wd;
        word_t   er;
        logic    eh;
        vector_t v;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", INPUT_FILE);
            stop_run();
        end
        while ($fgets(text, fd) != 0) begin
            if (!is_comment_line(text)) begin
                fields = $sscanf(text, "%h %h %h %h %h %h", w, sz, a, wd, er, eh);
                if (fields != 6) begin
                    $display("Malformed stimulus line: %s", text);
                    stop_run();
                end
                v = '{write: w, size: sz, addr: a, wdata: wd, exp_rdata: er, exp_hit: eh};
                vectors.push_back(v);
            end
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            $display("The stimulus file holds no accesses");
            stop_run();
        end
        loaded = 1'b1;
    endtask

    // Called on a falling edge, returns on the falling edge after completion
    task automatic run_access(input vector_t v, output word_t rdata, output int cycles,
                              output int reads);
        int reads_before;
        core_cmd.addr  = v.addr;
        core_cmd.write = v.write;
        core_cmd.size  = v.size;
        core_cmd.wdata = v.wdata;
        core_req       = 1'b1;
        reads_before   = read_count;
        cycles         = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (core_wait);
        rdata = core_rdata;
        reads = read_count - reads_before;
        @(negedge clk);
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        word_t rdata;
        int    cycles;
        int    reads;
        rst      = 1'b1;
        core_req = 1'b0;
        core_cmd = '0;
        load_vectors();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_flag("mem_req", 1'b0, mem_req);
        check_flag("core_wait", 1'b0, core_wait);
        foreach (vectors[i]) begin
            run_access(vectors[i], rdata, cycles, reads);
            // No memory read during a load means it hit
            if (!vectors[i].write) begin
                check_rdata($sformatf("core_rdata @ %h", vectors[i].addr),
                            vectors[i].exp_rdata, rdata);
                check_flag($sformatf("hit flag @ %h", vectors[i].addr),
                           vectors[i].exp_hit, reads == 0);
                if (vectors[i].exp_hit) begin
                    check_cycles($sformatf("hit latency @ %h", vectors[i].addr),
                                 HIT_CYCLES, cycles);
                end
            end
        end
        core_req = 1'b0;
        $display("TB PASSED");
        $finish;
    end

    // Limit scales with the number of accesses
    initial begin
        int limit;
        wait (loaded);
        limit = RESET_CYCLES + vectors.size() * CYCLES_PER_VECTOR;
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles, an access never completed", limit);
        stop_run();
    end

endmodule

`default_nettype wire

// ==== bench/tb_mem_model.sv ====
`default_nettype none

module tb_mem_model (
    input  logic                 clk,
    input  logic                 mem_req,
    input  dcache_pkg::mem_cmd_t mem_cmd,
    output logic                 mem_wait,
    output dcache_pkg::word_t    mem_rdata,
    output int                   read_count
);

    timeunit 1ns;
    timeprecision 100ps;

    import dcache_pkg::*;

    // Sparse word store keyed by word address
    word_t  mem_words [logic [29:0]];
    integer seed;
    int     stall;
    logic   busy;

    function automatic word_t read_word(input logic [29:0] key);
        if (mem_words.exists(key)) begin
            return mem_words[key];
        end
        return {2'b00, key} ^ 32'h5a5a_0000;
    endfunction

    // Only the addressed lanes change, data sits in the low bits
    task automatic apply_write(input mem_cmd_t cmd);
        addr_fields_t f;
        word_t        cur;
        int           lane;
        f    = cmd.addr;
        cur  = read_word(cmd.addr[31:2]);
        lane = int'(f.byte_off);
        case (cmd.size)
            SIZE_BYTE: cur[8*lane +: 8] = cmd.wdata[7:0];
            SIZE_HALF: cur[16*(lane/2) +: 16] = cmd.wdata[15:0];
            default:   cur = cmd.wdata;
        endcase
        mem_words[cmd.addr[31:2]] = cur;
    endtask

    // ======================================================================
    // Responder, decides each cycle on the falling edge
    // ======================================================================

    initial begin
        seed       = 32'hba6d_90b4;
        mem_wait   = 1'b1;
        mem_rdata  = '0;
        read_count = 0;
        busy       = 1'b0;
        stall      = 0;
        forever begin
            @(negedge clk);
            if (!mem_req) begin
                busy = 1'b0;
                mem_wait <= 1'b1;
            end else begin
                // New transfer draws 0 to 3 wait cycles
                if (!busy) begin
                    busy  = 1'b1;
                    stall = int'($random(seed) & 32'h3);
                end
                if (stall > 0) begin
                    stall--;
                    mem_wait <= 1'b1;
                end else begin
                    // Completes at the next rising edge
                    busy = 1'b0;
                    mem_wait <= 1'b0;
                    if (mem_cmd.write) begin
                        apply_write(mem_cmd);
                    end else begin
                        mem_rdata  <= read_word(mem_cmd.addr[31:2]);
                        read_count <= read_count + 1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dcache_top.sv ====
`default_nettype none

`include "dcache_cfg.svh"

module dcache_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  core_req,
    input  dcache_pkg::core_cmd_t core_cmd,
    output logic                  core_wait,
    output dcache_pkg::word_t     core_rdata,
    output logic                  mem_req,
    output dcache_pkg::mem_cmd_t  mem_cmd,
    input  dcache_pkg::word_t     mem_rdata,
    input  logic                  mem_wait
);

    import dcache_pkg::*;

    logic [`DCACHE_INDEX_BITS-1:0] index;
    logic                          tag_wr;
    logic [`DCACHE_TAG_BITS-1:0]   tag_wdata;
    logic [`DCACHE_TAG_BITS-1:0]   tag_rdata;
    logic                          line_valid;
    line_be_t                      line_we;
    cache_line_u                   line_wdata;
    cache_line_u                   line_rdata;
    line_be_t                      store_be;
    cache_line_u                   store_line;

    dcache_ctrl i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .core_req   (core_req),
        .core_cmd   (core_cmd),
        .core_wait  (core_wait),
        .core_rdata (core_rdata),
        .mem_req    (mem_req),
        .mem_cmd    (mem_cmd),
        .mem_wait   (mem_wait),
        .mem_rdata  (mem_rdata),
        .index      (index),
        .tag_wr     (tag_wr),
        .tag_wdata  (tag_wdata),
        .tag_rdata  (tag_rdata),
        .line_valid (line_valid),
        .line_we    (line_we),
        .line_wdata (line_wdata),
        .line_rdata (line_rdata),
        .store_be   (store_be),
        .store_line (store_line)
    );

    // Outside refill, mem_cmd carries the registered core command
    dcache_store_merge i_store_merge (
        .size       (mem_cmd.size),
        .fields     (mem_cmd.addr),
        .wdata      (mem_cmd.wdata),
        .store_be   (store_be),
        .store_line (store_line)
    );

    dcache_tag_array i_tag_array (
        .clk        (clk),
        .rst        (rst),
        .index      (index),
        .tag_wr     (tag_wr),
        .tag_wdata  (tag_wdata),
        .tag_rdata  (tag_rdata),
        .line_valid (line_valid)
    );

    dcache_data_array i_data_array (
        .clk        (clk),
        .index      (index),
        .line_we    (line_we),
        .line_wdata (line_wdata),
        .line_rdata (line_rdata)
    );

endmodule

`default_nettype wire

// ==== verilog/dcache_ctrl.sv ====
`default_nettype none

`include "dcache_cfg.svh"

module dcache_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    // Core side
    input  logic                          core_req,
    input  dcache_pkg::core_cmd_t         core_cmd,
    output logic                          core_wait,
    output dcache_pkg::word_t             core_rdata,
    // Memory side
    output logic                          mem_req,
    output dcache_pkg::mem_cmd_t          mem_cmd,
    input  logic                          mem_wait,
    input  dcache_pkg::word_t             mem_rdata,
    // Tag array
    output logic [`DCACHE_INDEX_BITS-1:0] index,
    output logic                          tag_wr,
    output logic [`DCACHE_TAG_BITS-1:0]   tag_wdata,
    input  logic [`DCACHE_TAG_BITS-1:0]   tag_rdata,
    input  logic                          line_valid,
    // Data array
    output dcache_pkg::line_be_t          line_we,
    output dcache_pkg::cache_line_u       line_wdata,
    input  dcache_pkg::cache_line_u       line_rdata,
    // Store merge
    input  dcache_pkg::line_be_t          store_be,
    input  dcache_pkg::cache_line_u       store_line
);

    import dcache_pkg::*;

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_LOOKUP = 3'd1;
    localparam logic [2:0] S_WRITE  = 3'd2;
    localparam logic [2:0] S_REFILL = 3'd3;
    localparam logic [2:0] S_BYPASS = 3'd4;
    localparam logic [2:0] S_DONE   = 3'd5;

    logic [2:0]   state;
    logic [2:0]   state_next;
    core_cmd_t    cmd_q;
    addr_fields_t core_fields;
    addr_fields_t cmd_fields;
    logic         cacheable;
    logic         hit;
    logic         beat_done;
    logic         last_beat;
    logic [1:0]   beat;
    cache_line_u  refill_buf;
    cache_line_u  fill_line;
    word_t        rdata_q;

    assign core_fields = core_cmd.addr;
    assign cmd_fields  = cmd_q.addr;

    // Bypass regions decided from the incoming address
    assign cacheable = (core_cmd.addr[31:16] != `DCACHE_UNCACHED_A) &&
                       (core_cmd.addr[31:16] != `DCACHE_UNCACHED_B);

    // Only meaningful in the lookup cycle
    assign hit = line_valid && (tag_rdata == cmd_fields.tag);

    assign beat_done = mem_req && !mem_wait;
    assign last_beat = (state == S_REFILL) && beat_done && (beat == 2'd3);

    // ======================================================================
    // Controller FSM
    // ======================================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (core_req) begin
                    state_next = cacheable ? S_LOOKUP : S_BYPASS;
                end
            end
            S_LOOKUP: begin
                if (cmd_q.write) begin
                    state_next = S_WRITE;
                end else begin
                    state_next = hit ? S_DONE : S_REFILL;
                end
            end
            S_WRITE: begin
                if (!mem_wait) begin
                    state_next = S_DONE;
                end
            end
            S_REFILL: begin
                if (last_beat) begin
                    state_next = S_DONE;
                end
            end
            S_BYPASS: begin
                if (!mem_wait) begin
                    state_next = S_DONE;
                end
            end
            default: state_next = S_IDLE;
        endcase
    end

    // Beat counter wraps back to zero after the fourth word
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beat <= 2'd0;
        end else if ((state == S_REFILL) && beat_done) begin
            beat <= beat + 2'd1;
        end
    end

    // ======================================================================
    // Command, refill buffer and read data
    // ======================================================================

    always_ff @(posedge clk) begin
        if ((state == S_IDLE) && core_req) begin
            cmd_q <= core_cmd;
        end
        if ((state == S_REFILL) && beat_done) begin
            refill_buf.words[beat] <= mem_rdata;
        end
        if ((state == S_LOOKUP) && !cmd_q.write && hit) begin
            rdata_q <= line_rdata.words[cmd_fields.word_off];
        end else if (last_beat) begin
            rdata_q <= fill_line.words[cmd_fields.word_off];
        end else if ((state == S_BYPASS) && !mem_wait) begin
            rdata_q <= mem_rdata;
        end
    end

    // Buffer plus the beat arriving this cycle
    always_comb begin
        fill_line              = refill_buf;
        fill_line.words[beat]  = mem_rdata;
    end

    // ======================================================================
    // Outputs
    // ======================================================================

    always_comb begin
        case (state)
            S_IDLE:  core_wait = core_req;
            S_DONE:  core_wait = 1'b0;
            default: core_wait = 1'b1;
        endcase
    end

    assign core_rdata = rdata_q;

    assign mem_req = (state == S_WRITE) || (state == S_REFILL) || (state == S_BYPASS);

    // Registered command, except refill beats of the aligned line
    always_comb begin
        mem_cmd.addr  = cmd_q.addr;
        mem_cmd.write = cmd_q.write;
        mem_cmd.size  = cmd_q.size;
        mem_cmd.wdata = cmd_q.wdata;
        if (state == S_REFILL) begin
            mem_cmd.addr  = {cmd_q.addr[31:4], beat, 2'b00};
            mem_cmd.write = 1'b0;
            mem_cmd.size  = SIZE_WORD;
            mem_cmd.wdata = '0;
        end
    end

    // Incoming index in idle so the lookup data is ready one cycle later
    assign index = (state == S_IDLE) ? core_fields.index : cmd_fields.index;

    assign tag_wr    = last_beat;
    assign tag_wdata = cmd_fields.tag;

    // Store hit updates its bytes, a refill writes the whole line
    always_comb begin
        if ((state == S_LOOKUP) && cmd_q.write && hit) begin
            line_we = store_be;
        end else if (last_beat) begin
            line_we = '1;
        end else begin
            line_we = '0;
        end
    end

    assign line_wdata = (state == S_REFILL) ? fill_line : store_line;

endmodule

`default_nettype wire

// ==== verilog/dcache_store_merge.sv ====
`default_nettype none

module dcache_store_merge (
    input  dcache_pkg::size_t        size,
    input  dcache_pkg::addr_fields_t fields,
    input  dcache_pkg::word_t        wdata,
    output dcache_pkg::line_be_t     store_be,
    output dcache_pkg::cache_line_u  store_line
);

    import dcache_pkg::*;

    logic [3:0] lane_mask;
    word_t      lane_data;

    // Lanes within the word, data replicated so every lane is correct
    always_comb begin
        case (size)
            SIZE_BYTE: begin
                lane_mask = 4'b0001 << fields.byte_off;
                lane_data = {4{wdata[7:0]}};
            end
            SIZE_HALF: begin
                lane_mask = fields.byte_off[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{wdata[15:0]}};
            end
            default: begin
                lane_mask = 4'b1111;
                lane_data = wdata;
            end
        endcase
    end

    // Word offset picks the nibble of the line enable
    assign store_be = line_be_t'(lane_mask) << {fields.word_off, 2'b00};

    always_comb begin
        store_line.words = {4{lane_data}};
    end

endmodule

`default_nettype wire

// ==== verilog/dcache_data_array.sv ====
`default_nettype none

`include "dcache_cfg.svh"

module dcache_data_array (
    input  logic                          clk,
    input  logic [`DCACHE_INDEX_BITS-1:0] index,
    input  dcache_pkg::line_be_t          line_we,
    input  dcache_pkg::cache_line_u       line_wdata,
    output dcache_pkg::cache_line_u       line_rdata
);

    localparam int LINES = 1 << `DCACHE_INDEX_BITS;

    logic [127:0] line_mem [LINES];

    // ======================================================================
    // Single port, byte-lane writes
    // ======================================================================

    // Partial store updates and full refills share this port
    always_ff @(posedge clk) begin
        for (int b = 0; b < 16; b++) begin
            if (line_we[b]) begin
                line_mem[index][8*b +: 8] <= line_wdata.bits[8*b +: 8];
            end
        end
    end

    // Old contents on a same-cycle write
    always_ff @(posedge clk) begin
        line_rdata.bits <= line_mem[index];
    end

endmodule

`default_nettype wire

// ==== verilog/dcache_tag_array.sv ====
`default_nettype none

`include "dcache_cfg.svh"

module dcache_tag_array (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [`DCACHE_INDEX_BITS-1:0] index,
    input  logic                          tag_wr,
    input  logic [`DCACHE_TAG_BITS-1:0]   tag_wdata,
    output logic [`DCACHE_TAG_BITS-1:0]   tag_rdata,
    output logic                          line_valid
);

    logic [`DCACHE_TAG_BITS-1:0] tag_mem [`DCACHE_LINES];
    logic [`DCACHE_LINES-1:0]    valid;

    // Tag storage, registered read
    always_ff @(posedge clk) begin
        if (tag_wr) begin
            tag_mem[index] <= tag_wdata;
        end
        tag_rdata <= tag_mem[index];
    end

    // Valid bits, set by every tag write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid      <= '0;
            line_valid <= 1'b0;
        end else begin
            if (tag_wr) begin
                valid[index] <= 1'b1;
            end
            line_valid <= valid[index];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dcache_pkg.sv ====
`default_nettype none

`include "dcache_cfg.svh"

package dcache_pkg;

    // Basic data word
    typedef logic [31:0] word_t;

    // Access size, takes one of the size codes
    typedef logic [1:0] size_t;

    localparam size_t SIZE_BYTE = `DCACHE_SIZE_BYTE;
    localparam size_t SIZE_HALF = `DCACHE_SIZE_HALF;
    localparam size_t SIZE_WORD = `DCACHE_SIZE_WORD;

    // Address split for a 64-line, 16-byte-line cache
    typedef struct packed {
        logic [`DCACHE_TAG_BITS-1:0]   tag;
        logic [`DCACHE_INDEX_BITS-1:0] index;
        logic [1:0]                    word_off;
        logic [1:0]                    byte_off;
    } addr_fields_t;

    // Request from the core, 67 bits
    typedef struct packed {
        word_t addr;
        logic  write;
        size_t size;
        word_t wdata;
    } core_cmd_t;

    // Request toward memory, same layout as the core side
    typedef struct packed {
        word_t addr;
        logic  write;
        size_t size;
        word_t wdata;
    } mem_cmd_t;

    // One enable per byte of a line
    typedef logic [15:0] line_be_t;

    // Flat view for the array port, word view for select and refill
    typedef union packed {
        logic [127:0]    bits;
        word_t [3:0]     words;
    } cache_line_u;

endpackage

`default_nettype wire

// ==== verilog/dcache_cfg.svh ====
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// ======================================================================
// Cache geometry
// ======================================================================

// 64 direct-mapped lines of four 32-bit words
`define DCACHE_LINES      64
`define DCACHE_INDEX_BITS 6

// Address bits above index and line offset
`define DCACHE_TAG_BITS   22

// ======================================================================
// Uncacheable regions
// ======================================================================

// Matched against address bits 31:16
`define DCACHE_UNCACHED_A 16'h1000
`define DCACHE_UNCACHED_B 16'h4000

// ======================================================================
// Access size codes
// ======================================================================

`define DCACHE_SIZE_BYTE  2'b00
`define DCACHE_SIZE_HALF  2'b01
`define DCACHE_SIZE_WORD  2'b10

`endif
